/* sim.f */
logic/riscv_isa_pkg.sv
logic/r5p_ctl_pkg.sv
logic/r5p_dec.sv
logic/r5p_gpr.sv
logic/r5p_alu.sv
logic/r5p_exe.sv
verification/r5p_exe_chk.sv
verification/r5p_exe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the r5p_exe testbench with verilator and runs it
# exits non-zero on a build error, a simulator error or a failing test

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module r5p_exe_tb -Mdir "$OBJ" -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vr5p_exe_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "failures found in $LOG"
  exit 1
fi

exit 0

/* verification/r5p_exe_tb.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// drives r5p_exe at XLEN 64 only
// each slot's outputs are checked one slot later
////////////////////////////////////////////////////////////

module r5p_exe_tb;
  import riscv_isa_pkg::*;

  localparam int unsigned XLEN    = 64;
  localparam time         PERIOD  = 100;
  localparam time         SKEW    = 5;   // drive delay after posedge
  localparam int          RST_CYC = 10;

  localparam int N_OP  = 400;
  localparam int N_W   = 300;
  localparam int N_AM  = 150;
  localparam int N_ILL = 100;
  localparam int N_DEP = 200;
  // worst case slot count with test 2 idle gaps, fills and readback
  localparam int  N_SLOT   = 2 * N_OP + N_W + N_AM + N_ILL + N_DEP + 3 * 32 + 16;
  localparam time WATCHDOG = (RST_CYC + N_SLOT + 100) * PERIOD;

  // predicted outputs of one issue slot
  typedef struct packed {
    logic            rv;
    logic [4:0]      idx;
    logic [XLEN-1:0] res;
    logic            av;
    logic [XLEN-1:0] adr;
    logic            ill;
  } expect_t;

  logic            clk;
  logic            rst;
  logic            inst_vld;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc;
  logic            res_vld;
  gpr_idx_t        res_idx;
  logic [XLEN-1:0] res;
  logic            adr_vld;
  logic [XLEN-1:0] adr;
  logic            ill;

  logic [XLEN-1:0] regs [0:31];  // model register file where x0 stays 0
  expect_t         exp_q [$];
  logic [31:0]     rng;
  int              n_pass;
  int              n_fail;
  int              test_err;     // errors of the running test

  r5p_exe #(.XLEN(XLEN)) dut0 (
    .clk      (clk),
    .rst      (rst),
    .inst_vld (inst_vld),
    .inst     (inst),
    .pc       (pc),
    .res_vld  (res_vld),
    .res_idx  (res_idx),
    .res      (res),
    .adr_vld  (adr_vld),
    .adr      (adr),
    .ill      (ill)
  );

  bind r5p_exe r5p_exe_chk chk0 (
    .clk      (clk),
    .rst      (rst),
    .inst_vld (inst_vld),
    .res_vld  (res_vld),
    .adr_vld  (adr_vld),
    .ill      (ill),
    .res_idx  (res_idx)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random numbers and encodings
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = rand32();
    return {hi, rand32()};
  endfunction

  // x0 picked often on purpose
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = rand32();
    if (r[7:5] == 3'd0) return 5'd0;
    return r[4:0];
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // legal op and op-imm or their word classes
  function automatic logic [31:0] alu_inst(input logic word, input logic [4:0] rs1,
      input logic [4:0] rd);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rs2;
    r   = rand32();
    rs2 = pick_reg();
    f3  = r[2:0];
    if (word) begin
      case (r[6:5])  // word forms only add, sll, sr
        2'd0:    f3 = ADD_SUB;
        2'd1:    f3 = SLL;
        default: f3 = SR;
      endcase
    end
    f7 = (r[3] && (f3 == ADD_SUB || f3 == SR)) ? F7_ALT : 7'h00;
    if (!r[4]) return r_type(f7, rs2, rs1, f3, rd, word ? OP_32 : OP);
    if (f3 == SLL || f3 == SR) begin
      if (word) return r_type(f7, r[20:16], rs1, f3, rd, OP_IMM_32);  // 5 bit shamt
      return i_type({f7[6:1], r[21:16]}, rs1, f3, rd, OP_IMM);         // 6 bit shamt
    end
    return i_type(r[31:20], rs1, f3, rd, word ? OP_IMM_32 : OP_IMM);  // no sub form
  endfunction

  // auipc, load or store
  function automatic logic [31:0] addr_inst();
    logic [31:0] r;
    logic [4:0]  ra;
    logic [4:0]  rb;
    r  = rand32();
    ra = pick_reg();
    rb = pick_reg();
    case (r[1:0])
      2'd0:    return u_type(r[31:12], ra, AUIPC);
      2'd1:    return i_type(r[31:20], ra, r[14:12], rb, LOAD);
      default: return s_type(r[31:20], ra, rb, r[14:12], STORE);
    endcase
  endfunction

  function automatic logic [31:0] illegal_inst();
    logic [31:0] r;
    logic [31:0] q;
    logic [6:0]  opc;
    logic [6:0]  f7;
    r = rand32();
    q = rand32();
    if (r[0]) begin
      opc = r[7:1];  // step off any handled opcode
      while (opc inside {LOAD, OP_IMM, AUIPC, OP_IMM_32, STORE, OP, OP_32}) opc = opc + 7'd1;
      return {q[31:7], opc};
    end
    f7 = r[10:4];
    if (f7 == 7'h00 || (f7 == F7_ALT && (r[3:1] == ADD_SUB || r[3:1] == SR)))
      f7 = f7 | 7'h01;
    return r_type(f7, q[4:0], q[9:5], r[3:1], q[14:10], OP);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model from the RV64I definitions
  ////////////////////////////////////////////////////////////

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] full_op(input logic [2:0] f3, input logic alt,
      input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b010:  return {63'd0, $signed(a) < $signed(b)};
      3'b011:  return {63'd0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[5:0];  // sign filled
        return a >> b[5:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // 32 bit op with bit 31 extended
  function automatic logic [63:0] word_op(input logic [2:0] f3, input logic alt,
      input logic [63:0] a, input logic [63:0] b);
    logic [31:0] v;
    case (f3)
      3'b000:  v = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      3'b001:  v = a[31:0] << b[4:0];
      default: begin
        if (alt) v = $signed(a[31:0]) >>> b[4:0];
        else     v = a[31:0] >> b[4:0];
      end
    endcase
    return sext32(v);
  endfunction

  task automatic model_exec(input logic [31:0] in, input logic [63:0] pc_in,
      output expect_t e);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] val;
    logic        legal;
    logic        wr;
    logic        mem;
    f7    = in[31:25];
    f3    = in[14:12];
    rd    = in[11:7];
    a     = regs[in[19:15]];
    b     = regs[in[24:20]];
    imm_i = {{52{in[31]}}, in[31:20]};
    legal = 1'b1;
    wr    = 1'b0;
    mem   = 1'b0;
    val   = '0;
    case (in[6:0])
      OP: begin
        wr    = 1'b1;
        legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        val   = full_op(f3, in[30], a, b);
      end
      OP_IMM: begin
        wr = 1'b1;
        if (f3 == 3'b001) legal = in[31:26] == 6'b000000;
        if (f3 == 3'b101) legal = in[31:26] == 6'b000000 || in[31:26] == 6'b010000;
        val = full_op(f3, f3 == 3'b101 && in[30], a, imm_i);  // srai only
      end
      OP_32: begin
        wr    = 1'b1;
        legal = f3 inside {3'b000, 3'b001, 3'b101} &&
                (f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'b001));
        val   = word_op(f3, in[30], a, b);
      end
      OP_IMM_32: begin
        wr    = 1'b1;
        legal = f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'h00) ||
                (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
        val   = word_op(f3, f3 == 3'b101 && in[30], a, imm_i);
      end
      AUIPC: begin
        wr  = 1'b1;
        val = pc_in + {{32{in[31]}}, in[31:12], 12'h000};
      end
      LOAD: begin
        wr  = 1'b1;  // rd marked with the address
        mem = 1'b1;
        val = a + imm_i;
      end
      STORE: begin
        mem = 1'b1;
        val = a + {{52{in[31]}}, in[31:25], in[11:7]};
      end
      default: legal = 1'b0;
    endcase
    e.rv  = legal && wr && rd != 5'd0;
    e.idx = rd;
    e.res = val;
    e.av  = legal && mem;
    e.adr = val;
    e.ill = !legal;
    if (e.rv) regs[rd] = val;
  endtask

  ////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////

  task automatic report_err(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    n_fail++;
    test_err++;
  endtask

  task automatic check_outputs();
    expect_t e;
    if (exp_q.size() == 0) return;
    e = exp_q.pop_front();
    if (res_vld !== e.rv) report_err("res_vld", e.rv, res_vld);
    else n_pass++;
    if (adr_vld !== e.av) report_err("adr_vld", e.av, adr_vld);
    else n_pass++;
    if (ill !== e.ill) report_err("ill", e.ill, ill);
    else n_pass++;
    if (e.rv) begin  // payload only meaningful with its pulse
      if (res_idx !== e.idx) report_err("res_idx", e.idx, res_idx);
      else n_pass++;
      if (res !== e.res) report_err("res", e.res, res);
      else n_pass++;
    end
    if (e.av) begin
      if (adr !== e.adr) report_err("adr", e.adr, adr);
      else n_pass++;
    end
  endtask

  // check the last slot then drive this one
  task automatic issue(input logic vld, input logic [31:0] word, input logic [63:0] pc_in);
    expect_t e;
    @(posedge clk);
    #(SKEW);
    check_outputs();
    inst_vld = vld;
    inst     = word;
    pc       = pc_in;
    if (vld) model_exec(word, pc_in, e);
    else e = '0;  // no pulses after an empty slot
    exp_q.push_back(e);
  endtask

  task automatic idle();
    issue(1'b0, rand32(), rand64());  // junk on inst while not valid
  endtask

  task automatic end_test(input string name);
    idle();  // checks the last instruction
    $display("test %s %s, %0d errors", name, (test_err == 0) ? "pass" : "fail", test_err);
    test_err = 0;
  endtask

  // wide random values via auipc
  task automatic fill_regs();
    logic [31:0] r;
    for (int i = 1; i < 32; i++) begin
      r = rand32();
      issue(1'b1, u_type(r[31:12], 5'(i), AUIPC), rand64());
    end
  endtask

  // add xi, xi, x0 shows every register on res
  task automatic readback_regs();
    for (int i = 1; i < 32; i++) begin
      issue(1'b1, r_type(7'h00, 5'd0, 5'(i), ADD_SUB, 5'(i), OP), rand64());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  prev;
    rng      = 32'h4dbc_154d;
    n_pass   = 0;
    n_fail   = 0;
    test_err = 0;
    rst      = 1'b1;
    inst_vld = 1'b0;
    inst     = '0;
    pc       = '0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    repeat (RST_CYC) @(posedge clk);
    #(SKEW);
    rst = 1'b0;

    // quiet after reset then add x5, x0, x0
    repeat (4) idle();
    issue(1'b1, r_type(7'h00, 5'd0, 5'd0, ADD_SUB, 5'd5, OP), rand64());
    end_test("reset");

    // op and op-imm with idle gaps
    fill_regs();
    for (int n = 0; n < N_OP; n++) begin
      r = rand32();
      if (r[2:0] == 3'd0) idle();
      issue(1'b1, alu_inst(1'b0, pick_reg(), pick_reg()), rand64());
    end
    end_test("alu");

    // word forms on full 64 bit operands
    fill_regs();
    for (int n = 0; n < N_W; n++) issue(1'b1, alu_inst(1'b1, pick_reg(), pick_reg()), rand64());
    end_test("word");

    // auipc, load and store
    for (int n = 0; n < N_AM; n++) issue(1'b1, addr_inst(), rand64());
    end_test("addr");

    // illegal encodings leave all registers alone
    for (int n = 0; n < N_ILL; n++) issue(1'b1, illegal_inst(), rand64());
    readback_regs();
    end_test("illegal");

    // each instruction reads the previous rd with no gaps
    prev = 5'd1;
    for (int n = 0; n < N_DEP; n++) begin
      r  = rand32();
      rd = pick_reg();
      if (rd == 5'd0) rd = 5'd1;
      issue(1'b1, alu_inst(r[0], prev, rd), rand64());
      prev = rd;
    end
    end_test("chain");

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG);
    $display("timeout, the tests did not finish within %0t", WATCHDOG);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/r5p_exe_chk.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// output pulse rules of r5p_exe, bound from the testbench
////////////////////////////////////////////////////////////

module r5p_exe_chk (
  input logic                     clk,
  input logic                     rst,
  input logic                     inst_vld,
  input logic                     res_vld,
  input logic                     adr_vld,
  input logic                     ill,
  input riscv_isa_pkg::gpr_idx_t  res_idx
);

  // every pulse answers an instruction one cycle earlier
  pulse_after_issue: assert property (@(posedge clk) disable iff (rst)
    (res_vld || adr_vld || ill) |-> $past(inst_vld))
    else $error("output pulse without a valid instruction in the cycle before");

  // illegal never writes
  res_not_ill: assert property (@(posedge clk) disable iff (rst) !(res_vld && ill))
    else $error("res_vld and ill high in the same cycle");

  // x0 is never reported as written
  res_idx_nonzero: assert property (@(posedge clk) disable iff (rst)
    res_vld |-> (res_idx != '0))
    else $error("res_vld high with res_idx zero");

endmodule

`default_nettype wire

/* logic/r5p_exe.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// execute slice top, one instruction per inst_vld cycle
// outputs pulse one cycle later, no back-pressure, no hold
////////////////////////////////////////////////////////////

module r5p_exe #(
  parameter int unsigned XLEN = 64
)(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inst_vld,
  input  logic [31:0]              inst,
  input  logic [XLEN-1:0]          pc,
  output logic                     res_vld,  // rd written
  output riscv_isa_pkg::gpr_idx_t  res_idx,
  output logic [XLEN-1:0]          res,
  output logic                     adr_vld,  // load/store address
  output logic [XLEN-1:0]          adr,
  output logic                     ill       // illegal instruction
);
  import riscv_isa_pkg::*;
  import r5p_ctl_pkg::*;

  ai_t             alu_ai;
  rt_t             alu_rt;
  ao_t             alu_ao;
  logic [XLEN-1:0] imm;
  gpr_idx_t        rs1_idx;
  gpr_idx_t        rs2_idx;
  gpr_idx_t        rd_idx;
  logic            wr_en;
  logic            mem_en;
  logic            dec_ill;
  logic            gpr_we;
  logic [XLEN-1:0] rs1_dat;
  logic [XLEN-1:0] rs2_dat;
  logic [XLEN-1:0] alu_rd;
  logic [XLEN:0]   sum;

  r5p_dec #(.XLEN(XLEN)) dec0 (
    .inst    (inst),
    .alu_ai  (alu_ai),
    .alu_rt  (alu_rt),
    .alu_ao  (alu_ao),
    .imm     (imm),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rd_idx  (rd_idx),
    .wr_en   (wr_en),
    .mem_en  (mem_en),
    .dec_ill (dec_ill)
  );

  assign gpr_we = inst_vld & wr_en;  // only on a valid instruction

  r5p_gpr #(.XLEN(XLEN)) gpr0 (
    .clk     (clk),
    .rst     (rst),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rd_idx  (rd_idx),
    .wr_en   (gpr_we),
    .rd_dat  (alu_rd),
    .rs1_dat (rs1_dat),
    .rs2_dat (rs2_dat)
  );

  r5p_alu #(.XLEN(XLEN)) alu0 (
    .clk (clk),
    .rst (rst),
    .ai  (alu_ai),
    .rt  (alu_rt),
    .ao  (alu_ao),
    .imm (imm),
    .pc  (pc),
    .rs1 (rs1_dat),
    .rs2 (rs2_dat),
    .rd  (alu_rd),
    .sum (sum)
  );

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  // pulses, high for exactly one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      res_vld <= 1'b0;
      adr_vld <= 1'b0;
      ill     <= 1'b0;
    end else begin
      res_vld <= gpr_we;
      adr_vld <= inst_vld & mem_en;
      ill     <= inst_vld & dec_ill;
    end
  end

  // payload, only loaded alongside its pulse
  always_ff @(posedge clk) begin
    if (gpr_we) begin
      res     <= alu_rd;
      res_idx <= rd_idx;
    end
    if (inst_vld && mem_en) adr <= sum[XLEN-1:0];  // drop extension bit
  end

endmodule

`default_nettype wire

/* logic/r5p_alu.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// combinational alu, clk and rst are unused ports
// word results (R_SW/R_UW) need XLEN 64
////////////////////////////////////////////////////////////

module r5p_alu #(
  parameter int unsigned XLEN = 64
)(
  input  logic              clk,   // not used
  input  logic              rst,   // not used
  input  r5p_ctl_pkg::ai_t  ai,
  input  r5p_ctl_pkg::rt_t  rt,
  input  r5p_ctl_pkg::ao_t  ao,
  input  logic [XLEN-1:0]   imm,   // already selected by decoder
  input  logic [XLEN-1:0]   pc,
  input  logic [XLEN-1:0]   rs1,
  input  logic [XLEN-1:0]   rs2,
  output logic [XLEN-1:0]   rd,    // result
  output logic [XLEN:0]     sum    // adder incl. extension bit
);
  import r5p_ctl_pkg::*;

  localparam int unsigned XLOG = $clog2(XLEN);

  logic [XLEN-1:0] in1;  // muxed operands
  logic [XLEN-1:0] in2;
  logic [XLEN:0]   op1;  // extended by one bit
  logic [XLEN:0]   op2;
  logic            inv;  // subtract
  logic            word;
  logic [XLOG-1:0] sam;  // shift amount, muxed
  logic [XLOG-1:0] sa;   // shift amount, limited
  logic [XLEN-1:0] shi;  // shifter input
  logic [XLEN-1:0] val;

  // one bit extension by result type
  function automatic logic [XLEN:0] ext(input logic [XLEN-1:0] v, input rt_t t);
    case (t)
      R_SX:    ext = (XLEN+1)'(signed'(v));
      R_UX:    ext = (XLEN+1)'(v);
      R_SW:    ext = (XLEN+1)'(signed'(v[31:0]));
      default: ext = (XLEN+1)'(v[31:0]);  // R_UW
    endcase
  endfunction

  assign word = rt inside {R_SW, R_UW};

  // operand mux
  always_comb begin
    in1 = rs1;
    in2 = imm;
    case (ai)
      AI_R1_R2: in2 = rs2;
      AI_R1_II,
      AI_R1_IL,
      AI_R1_IS: in2 = imm;
      AI_PC_IU: in1 = pc;   // auipc
      default:  in2 = rs2;  // unused codes
    endcase
  end

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  assign op1 = ext(in1, rt);
  assign op2 = ext(in2, rt);

  // sub and both compares use op1 - op2
  assign inv = ao.f7_5 | (ao ==? AO_SLT) | (ao ==? AO_SLTU);

  // msb of the difference is the compare result
  assign sum = op1 + (inv ? ~op2 : op2) + (XLEN+1)'(inv);

  ////////////////////////////////////////////////////////////
  // shifter
  ////////////////////////////////////////////////////////////

  assign sam = (ai == AI_R1_R2) ? rs2[XLOG-1:0] : imm[XLOG-1:0];
  assign sa  = word ? XLOG'(sam[4:0]) : sam;  // 5 bit shamt on words

  // word shifts only see rs1[31:0], sign filled for sraw
  always_comb begin
    if (!word)        shi = rs1;
    else if (ao.f7_5) shi = XLEN'(signed'(rs1[31:0]));
    else              shi = XLEN'(rs1[31:0]);
  end

  ////////////////////////////////////////////////////////////
  // result
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique casez (ao)
      AO_ADD,
      AO_SUB:  val = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: val = XLEN'(sum[XLEN]);
      AO_AND:  val = in1 & in2;
      AO_OR:   val = in1 | in2;
      AO_XOR:  val = in1 ^ in2;
      AO_SLL:  val = shi << sa;
      AO_SRL:  val = shi >> sa;
      AO_SRA:  val = $signed(shi) >>> sa;
      default: val = '0;
    endcase
  end

  // word results sign extend bit 31
  assign rd = word ? XLEN'(signed'(val[31:0])) : val;

endmodule

`default_nettype wire

/* logic/r5p_gpr.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// 2r1w register file, asynchronous reads, x0 reads zero
////////////////////////////////////////////////////////////

module r5p_gpr #(
  parameter int unsigned XLEN = 64
)(
  input  logic                     clk,
  input  logic                     rst,
  input  riscv_isa_pkg::gpr_idx_t  rs1_idx,
  input  riscv_isa_pkg::gpr_idx_t  rs2_idx,
  input  riscv_isa_pkg::gpr_idx_t  rd_idx,
  input  logic                     wr_en,
  input  logic [XLEN-1:0]          rd_dat,
  output logic [XLEN-1:0]          rs1_dat,
  output logic [XLEN-1:0]          rs2_dat
);

  // x1 .. x31, no storage for x0
  logic [XLEN-1:0] gpr [1:31];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;  // all registers read zero after reset
      end
    end else if (wr_en && (rd_idx != '0)) begin
      gpr[rd_idx] <= rd_dat;  // x0 writes dropped
    end
  end

  // read ports
  // a write shows up on the next cycle's read, no bypass
  assign rs1_dat = (rs1_idx == '0) ? '0 : gpr[rs1_idx];
  assign rs2_dat = (rs2_idx == '0) ? '0 : gpr[rs2_idx];

endmodule

`default_nettype wire

/* logic/r5p_dec.sv */
`timescale 1ns/1ns
`default_nettype none
////////////////////////////////////////////////////////////
// purely combinational decoder, one immediate pre-selected
// load/store funct3 is not checked, only the address is used
////////////////////////////////////////////////////////////

module r5p_dec #(
  parameter int unsigned XLEN = 64
)(
  input  logic [31:0]              inst,
  output r5p_ctl_pkg::ai_t         alu_ai,   // operand select
  output r5p_ctl_pkg::rt_t         alu_rt,   // result type
  output r5p_ctl_pkg::ao_t         alu_ao,   // operation
  output logic [XLEN-1:0]          imm,      // selected immediate
  output riscv_isa_pkg::gpr_idx_t  rs1_idx,
  output riscv_isa_pkg::gpr_idx_t  rs2_idx,
  output riscv_isa_pkg::gpr_idx_t  rd_idx,
  output logic                     wr_en,    // rd write, never for x0
  output logic                     mem_en,   // load or store address
  output logic                     dec_ill   // not decodable
);
  import riscv_isa_pkg::*;
  import r5p_ctl_pkg::*;

  localparam bit RV64 = (XLEN == 64);  // word forms exist

  opc_t            opc;
  fn3_t            fn3;
  logic [6:0]      f7;
  logic [6:0]      f7_shi;  // funct7 with the shamt msb masked on rv64
  logic            alt_ok;  // funct3 allows F7_ALT
  logic            alu_op;  // one of the four integer classes
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;
  logic            word;
  logic            wr;
  logic            mem;
  logic            bad;
  logic            f7_5;

  // fixed fields
  assign opc     = opc_t'(inst[6:0]);
  assign fn3     = fn3_t'(inst[14:12]);
  assign f7      = inst[31:25];
  assign f7_shi  = RV64 ? {inst[31:26], 1'b0} : inst[31:25];
  assign rs1_idx = inst[19:15];
  assign rs2_idx = inst[24:20];
  assign rd_idx  = inst[11:7];

  assign alt_ok = (fn3 == ADD_SUB) || (fn3 == SR);
  assign alu_op = opc inside {OP, OP_32, OP_IMM, OP_IMM_32};

  // immediates, sign extended to xlen
  assign imm_i = XLEN'(signed'(inst[31:20]));
  assign imm_s = XLEN'(signed'({inst[31:25], inst[11:7]}));
  assign imm_u = XLEN'(signed'({inst[31:12], 12'h000}));

  ////////////////////////////////////////////////////////////
  // opcode class
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_ai = AI_R1_R2;
    imm    = '0;
    word   = 1'b0;
    wr     = 1'b0;
    mem    = 1'b0;
    bad    = 1'b0;
    f7_5   = 1'b0;
    case (opc)
      OP: begin
        wr   = 1'b1;
        f7_5 = inst[30];
        bad  = !((f7 == '0) || ((f7 == F7_ALT) && alt_ok));
      end
      OP_32: begin
        wr   = 1'b1;
        word = 1'b1;
        f7_5 = inst[30];
        bad  = !RV64 || !(fn3 inside {ADD_SUB, SLL, SR}) ||
               !((f7 == '0) || ((f7 == F7_ALT) && alt_ok));
      end
      OP_IMM: begin
        alu_ai = AI_R1_II;
        imm    = imm_i;
        wr     = 1'b1;
        f7_5   = (fn3 == SR) && inst[30];  // srai only, else imm bit
        if (fn3 == SLL) bad = (f7_shi != '0);
        if (fn3 == SR)  bad = !((f7_shi == '0) || (f7_shi == F7_ALT));
      end
      OP_IMM_32: begin
        alu_ai = AI_R1_II;
        imm    = imm_i;
        wr     = 1'b1;
        word   = 1'b1;
        f7_5   = (fn3 == SR) && inst[30];
        case (fn3)
          ADD_SUB: bad = !RV64;                         // addiw
          SLL:     bad = !RV64 || (f7 != '0);           // shamt is 5 bits
          SR:      bad = !RV64 || !((f7 == '0) || (f7 == F7_ALT));
          default: bad = 1'b1;
        endcase
      end
      AUIPC: begin
        alu_ai = AI_PC_IU;
        imm    = imm_u;
        wr     = 1'b1;
      end
      LOAD: begin
        alu_ai = AI_R1_IL;
        imm    = imm_i;
        wr     = 1'b1;  // rd gets the address
        mem    = 1'b1;
      end
      STORE: begin
        alu_ai = AI_R1_IS;
        imm    = imm_s;
        mem    = 1'b1;
      end
      default: bad = 1'b1;  // unknown opcode
    endcase
  end

  // result type, sltu/sltiu compare unsigned
  always_comb begin
    if (word)                         alu_rt = R_SW;
    else if (alu_op && (fn3 == SLTU)) alu_rt = R_UX;
    else                              alu_rt = R_SX;
  end

  // address and auipc just add
  assign alu_ao = alu_op ? ao_t'{f7_5: f7_5, f3: fn3} : AO_ADD;

  assign wr_en   = wr && !bad && (rd_idx != '0);
  assign mem_en  = mem && !bad;
  assign dec_ill = bad;

endmodule

`default_nettype wire

/* logic/r5p_ctl_pkg.sv */
`default_nettype none
////////////////////////////////////////////////////////////
// alu control codes passed from decoder to alu
////////////////////////////////////////////////////////////

package r5p_ctl_pkg;

  // operand select
  typedef enum logic [2:0] {
    AI_R1_R2 = 3'd0,  // rs1 and rs2
    AI_R1_II = 3'd1,  // rs1 and I immediate
    AI_R1_IL = 3'd2,  // rs1 and load offset
    AI_R1_IS = 3'd3,  // rs1 and store offset
    AI_PC_IU = 3'd4   // pc and U immediate
  } ai_t;

  // result type, bit 1 marks word width
  typedef enum logic [1:0] {
    R_SX = 2'b00,  // signed xlen
    R_UX = 2'b01,  // unsigned xlen
    R_SW = 2'b10,  // signed word
    R_UW = 2'b11   // unsigned word
  } rt_t;

  ////////////////////////////////////////////////////////////
  // operation code, funct7 bit 5 on top of funct3
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       f7_5;  // sub / sra
    logic [2:0] f3;
  } ao_t;

  // ? is a wildcard, compare with ==? or casez
  localparam ao_t AO_ADD  = 4'b0000;
  localparam ao_t AO_SUB  = 4'b1000;
  localparam ao_t AO_SLL  = 4'b?001;
  localparam ao_t AO_SLT  = 4'b?010;
  localparam ao_t AO_SLTU = 4'b?011;
  localparam ao_t AO_XOR  = 4'b?100;
  localparam ao_t AO_SRL  = 4'b0101;
  localparam ao_t AO_SRA  = 4'b1101;
  localparam ao_t AO_OR   = 4'b?110;
  localparam ao_t AO_AND  = 4'b?111;

endpackage

`default_nettype wire

/* logic/riscv_isa_pkg.sv */
`default_nettype none
////////////////////////////////////////////////////////////
// rv base isa encodings for the execute slice
// only the opcode classes that the decoder handles are listed
////////////////////////////////////////////////////////////

package riscv_isa_pkg;

  //////////////////////////////////////////////////////////
  // major opcodes, inst[6:0]
  //////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    LOAD      = 7'b000_0011,  // address only here
    OP_IMM    = 7'b001_0011,
    AUIPC     = 7'b001_0111,
    OP_IMM_32 = 7'b001_1011,  // rv64 only
    STORE     = 7'b010_0011,  // address only here
    OP        = 7'b011_0011,
    OP_32     = 7'b011_1011   // rv64 only
  } opc_t;

  // funct3 of the integer ops, inst[14:12]
  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SR      = 3'b101,  // srl or sra by funct7
    OR      = 3'b110,
    AND     = 3'b111
  } fn3_t;

  // funct7 for sub, sra and srai
  localparam logic [6:0] F7_ALT = 7'b010_0000;

  // register index
  localparam int unsigned GPR_IW = 5;  // x0 .. x31
  typedef logic [GPR_IW-1:0] gpr_idx_t;

endpackage

`default_nettype wire
